/* design/baud_tick_gen.sv */
`timescale 1ns/1ps

module baud_tick_gen
	import uart_pkg::*;
(
	input  logic clk,
	input  logic arst_n,
	output logic tick
);

	logic [TICK_CNT_W-1:0] cnt; // Free running divider

	//////////////////////////////////////////////////
	// Divider
	//////////////////////////////////////////////////
	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			cnt <= '0;
		end
		else if (cnt == TICK_LAST)
		begin
			cnt <= '0; // Wrap
		end
		else
		begin
			cnt <= cnt + 1'b1;
		end
	end

	// One cycle pulse at the wrap
	assign tick = (cnt == TICK_LAST);

endmodule

/* design/byte_fifo.sv */
`timescale 1ns/1ps

module byte_fifo
	import uart_pkg::*;
(
	input  logic              clk,
	input  logic              arst_n,
	input  logic [DATA_W-1:0] w_data,
	input  logic              wr,
	input  logic              rd,
	output logic [DATA_W-1:0] r_data,
	output logic              full,
	output logic              empty
);

	logic [DATA_W-1:0]    mem [FIFO_DEPTH]; // Register array
	logic [FIFO_ADDR_W:0] wptr;             // Extra bit tells wrap
	logic [FIFO_ADDR_W:0] rptr;

	//////////////////////////////////////////////////
	// Pointers
	//////////////////////////////////////////////////
	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			wptr <= '0;
			rptr <= '0;
		end
		else
		begin
			if (wr)
				wptr <= wptr + 1'b1;
			if (rd)
				rptr <= rptr + 1'b1;
		end
	end

	// Storage
	always_ff @(posedge clk)
	begin
		if (wr)
			mem[wptr[FIFO_ADDR_W-1:0]] <= w_data;
	end

	// Head word always visible
	assign r_data = mem[rptr[FIFO_ADDR_W-1:0]];

	// Flags from pointer compare
	assign empty = (wptr == rptr);
	assign full  = (wptr[FIFO_ADDR_W] != rptr[FIFO_ADDR_W]) &&
		(wptr[FIFO_ADDR_W-1:0] == rptr[FIFO_ADDR_W-1:0]);

	//////////////////////////////////////////////////
	// Protocol checks on both neighbours
	//////////////////////////////////////////////////
	a_no_overflow: assert property (@(posedge clk) disable iff (!arst_n)
		!(wr && full));

	a_no_underflow: assert property (@(posedge clk) disable iff (!arst_n)
		!(rd && empty));

endmodule

/* design/loopback_tester.sv */
`timescale 1ns/1ps

module loopback_tester
	import uart_pkg::*;
(
	input  logic              clk,
	input  logic              arst_n,
	input  logic              test_req,
	input  logic [DATA_W-1:0] test_byte,
	input  logic [DATA_W-1:0] r_data,
	input  logic              rx_empty,
	input  logic              tx_full,
	output logic              test_ack,
	output logic              test_pass,
	output logic [DATA_W-1:0] w_data,
	output logic              wr,
	output logic              rd
);

	tester_state_t     state;
	tester_state_t     next_state;
	logic [DATA_W-1:0] rx_byte; // Byte that came back

	//////////////////////////////////////////////////
	// State register
	//////////////////////////////////////////////////
	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
			state <= T_IDLE;
		else
			state <= next_state;
	end

	// Next state
	always_comb
	begin
		next_state = state;
		case (state)
			T_IDLE:          if (test_req) next_state = T_WAIT_TX_SPACE;
			T_WAIT_TX_SPACE: if (!tx_full) next_state = T_SEND;
			T_SEND:          next_state = T_WAIT_RX_DATA; // Single write
			T_WAIT_RX_DATA:  if (!rx_empty) next_state = T_RECEIVE;
			T_RECEIVE:       next_state = T_COMPARE;
			T_COMPARE:       next_state = T_RESPOND;
			T_RESPOND:       if (!test_req) next_state = T_IDLE;
			default:         next_state = T_IDLE;
		endcase
	end

	// FIFO strobes straight from state
	assign wr     = (state == T_SEND);
	assign rd     = (state == T_RECEIVE);
	assign w_data = test_byte; // Source keeps it stable during req

	// Capture the head word while popping it
	always_ff @(posedge clk)
	begin
		if (state == T_RECEIVE)
			rx_byte <= r_data;
	end

	//////////////////////////////////////////////////
	// Handshake outputs
	//////////////////////////////////////////////////
	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			test_ack  <= 1'b0;
			test_pass <= 1'b0;
		end
		else if (state == T_COMPARE)
		begin
			test_ack  <= 1'b1;
			test_pass <= (rx_byte == test_byte); // Result valid with ack
		end
		else if (state == T_RESPOND && !test_req)
		begin
			test_ack  <= 1'b0; // One cycle after req drops
			test_pass <= 1'b0;
		end
	end

	// Ack only answers a live request
	a_ack_needs_req: assert property (@(posedge clk) disable iff (!arst_n)
		$rose(test_ack) |-> test_req);

endmodule

/* design/uart_loopback_top.sv */
`timescale 1ns/1ps

module uart_loopback_top
	import uart_pkg::*;
(
	input  logic              clk,
	input  logic              arst_n,
	input  logic              test_req,
	input  logic [DATA_W-1:0] test_byte,
	input  logic              rx,
	output logic              test_ack,
	output logic              test_pass,
	output logic              tx
);

	logic              tick;

	// Tester to serializer path
	logic [DATA_W-1:0] txf_w_data;
	logic              txf_wr;
	logic              txf_rd;
	logic [DATA_W-1:0] txf_r_data;
	logic              txf_full;
	logic              txf_empty;

	// Deserializer to tester path
	logic [DATA_W-1:0] rxf_w_data;
	logic              rxf_wr;
	logic              rxf_rd;
	logic [DATA_W-1:0] rxf_r_data;
	logic              rxf_full;
	logic              rxf_empty;

	//////////////////////////////////////////////////
	// Shared oversampling tick
	//////////////////////////////////////////////////
	baud_tick_gen u_tick (.clk(clk), .arst_n(arst_n), .tick(tick));

	byte_fifo tx_fifo (
		.clk(clk), .arst_n(arst_n),
		.w_data(txf_w_data), .wr(txf_wr), .rd(txf_rd),
		.r_data(txf_r_data), .full(txf_full), .empty(txf_empty)
	);

	byte_fifo rx_fifo (
		.clk(clk), .arst_n(arst_n),
		.w_data(rxf_w_data), .wr(rxf_wr), .rd(rxf_rd),
		.r_data(rxf_r_data), .full(rxf_full), .empty(rxf_empty)
	);

	uart_tx u_uart_tx (
		.clk(clk), .arst_n(arst_n), .tick(tick),
		.r_data(txf_r_data), .empty(txf_empty), .rd(txf_rd), .tx(tx)
	);

	uart_rx u_uart_rx (
		.clk(clk), .arst_n(arst_n), .tick(tick), .rx(rx),
		.full(rxf_full), .w_data(rxf_w_data), .wr(rxf_wr)
	);

	loopback_tester u_tester (
		.clk(clk), .arst_n(arst_n),
		.test_req(test_req), .test_byte(test_byte),
		.r_data(rxf_r_data), .rx_empty(rxf_empty), .tx_full(txf_full),
		.test_ack(test_ack), .test_pass(test_pass),
		.w_data(txf_w_data), .wr(txf_wr), .rd(rxf_rd)
	);

endmodule

/* design/uart_pkg.sv */
package uart_pkg;

	//////////////////////////////////////////////////
	// Frame and oversampling
	//////////////////////////////////////////////////
	localparam int DATA_W        = 8;  // Bits per serial byte
	localparam int OVERSAMPLE    = 16; // Ticks per serial bit
	localparam int CLKS_PER_TICK = 4;  // Small divider for fast simulation
	localparam int TICK_CNT_W    = $clog2(CLKS_PER_TICK);
	localparam int OS_CNT_W      = $clog2(OVERSAMPLE);
	localparam int BIT_CNT_W     = $clog2(DATA_W);

	// Terminal counts
	localparam logic [TICK_CNT_W-1:0] TICK_LAST = TICK_CNT_W'(CLKS_PER_TICK - 1);
	localparam logic [OS_CNT_W-1:0]   OS_LAST   = OS_CNT_W'(OVERSAMPLE - 1);
	localparam logic [OS_CNT_W-1:0]   OS_HALF   = OS_CNT_W'(OVERSAMPLE / 2 - 1); // Mid start bit
	localparam logic [BIT_CNT_W-1:0]  BIT_LAST  = BIT_CNT_W'(DATA_W - 1);

	//////////////////////////////////////////////////
	// FIFO geometry
	//////////////////////////////////////////////////
	localparam int FIFO_ADDR_W = 2;
	localparam int FIFO_DEPTH  = 1 << FIFO_ADDR_W; // 4 entries

	//////////////////////////////////////////////////
	// State encodings
	//////////////////////////////////////////////////
	typedef enum logic [2:0] {
		T_IDLE,          // Waiting for test_req
		T_WAIT_TX_SPACE, // tx FIFO full
		T_SEND,          // One write of test_byte
		T_WAIT_RX_DATA,  // Byte still on the wire
		T_RECEIVE,       // Pop and capture
		T_COMPARE,
		T_RESPOND        // Hold ack until req drops
	} tester_state_t;

	typedef enum logic [1:0] {TX_IDLE, TX_START, TX_DATA, TX_STOP} tx_state_t;

	typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_t;

endpackage

/* design/uart_rx.sv */
`timescale 1ns/1ps

module uart_rx
	import uart_pkg::*;
(
	input  logic              clk,
	input  logic              arst_n,
	input  logic              tick,
	input  logic              rx,
	input  logic              full,
	output logic [DATA_W-1:0] w_data,
	output logic              wr
);

	rx_state_t            state;
	logic                 rx_meta;  // First sync stage
	logic                 rx_sync;  // Safe to use
	logic                 rx_prev;  // For edge detect
	logic [OS_CNT_W-1:0]  tick_cnt;
	logic [BIT_CNT_W-1:0] bit_cnt;
	logic [DATA_W-1:0]    shreg;
	logic                 fall;

	//////////////////////////////////////////////////
	// Input synchronizer
	//////////////////////////////////////////////////
	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			rx_meta <= 1'b1;
			rx_sync <= 1'b1;
			rx_prev <= 1'b1;
		end
		else
		begin
			rx_meta <= rx;
			rx_sync <= rx_meta;
			rx_prev <= rx_sync;
		end
	end

	assign fall = rx_prev && !rx_sync;

	//////////////////////////////////////////////////
	// Deserializer FSM
	//////////////////////////////////////////////////
	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			state    <= RX_IDLE;
			tick_cnt <= '0;
			bit_cnt  <= '0;
			wr       <= 1'b0;
		end
		else
		begin
			wr <= 1'b0; // Single cycle strobe
			case (state)
				RX_IDLE:
				begin
					if (fall)
					begin
						state    <= RX_START;
						tick_cnt <= '0;
					end
				end
				RX_START:
				begin
					if (tick)
					begin
						tick_cnt <= tick_cnt + 1'b1;
						if (tick_cnt == OS_HALF)
						begin
							tick_cnt <= '0;
							bit_cnt  <= '0;
							// Glitch if line is back high
							state    <= rx_sync ? RX_IDLE : RX_DATA;
						end
					end
				end
				RX_DATA:
				begin
					if (tick)
					begin
						tick_cnt <= tick_cnt + 1'b1;
						if (tick_cnt == OS_LAST)
						begin
							bit_cnt <= bit_cnt + 1'b1;
							if (bit_cnt == BIT_LAST)
								state <= RX_STOP;
						end
					end
				end
				RX_STOP:
				begin
					if (tick)
					begin
						tick_cnt <= tick_cnt + 1'b1;
						if (tick_cnt == OS_LAST)
						begin
							state <= RX_IDLE;
							wr    <= rx_sync && !full; // Low stop or full FIFO drops it
						end
					end
				end
				default: state <= RX_IDLE;
			endcase
		end
	end

	// Mid-bit sample shifts in from the top, LSB arrives first
	always_ff @(posedge clk)
	begin
		if (state == RX_DATA && tick && tick_cnt == OS_LAST)
			shreg <= {rx_sync, shreg[DATA_W-1:1]};
	end

	assign w_data = shreg;

endmodule

/* design/uart_tx.sv */
`timescale 1ns/1ps

module uart_tx
	import uart_pkg::*;
(
	input  logic              clk,
	input  logic              arst_n,
	input  logic              tick,
	input  logic [DATA_W-1:0] r_data,
	input  logic              empty,
	output logic              rd,
	output logic              tx
);

	tx_state_t             state;
	logic [OS_CNT_W-1:0]   tick_cnt; // Ticks within the current bit
	logic [BIT_CNT_W-1:0]  bit_cnt;  // Data bit index
	logic [DATA_W-1:0]     shreg;    // Remaining data bits
	logic                  bit_end;

	assign bit_end = tick && (tick_cnt == OS_LAST);

	// Pop on the tick that starts the frame
	assign rd = (state == TX_IDLE) && tick && !empty;

	//////////////////////////////////////////////////
	// Serializer FSM
	//////////////////////////////////////////////////
	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			state    <= TX_IDLE;
			tick_cnt <= '0;
			bit_cnt  <= '0;
			tx       <= 1'b1; // Line idles high
		end
		else
		begin
			if (tick)
				tick_cnt <= tick_cnt + 1'b1; // Wraps at OVERSAMPLE
			case (state)
				TX_IDLE:
				begin
					if (rd)
					begin
						state    <= TX_START;
						tick_cnt <= '0;
						tx       <= 1'b0; // Start bit
					end
				end
				TX_START:
				begin
					if (bit_end)
					begin
						state   <= TX_DATA;
						bit_cnt <= '0;
						tx      <= shreg[0]; // LSB first
					end
				end
				TX_DATA:
				begin
					if (bit_end)
					begin
						if (bit_cnt == BIT_LAST)
						begin
							state <= TX_STOP;
							tx    <= 1'b1; // Stop bit
						end
						else
						begin
							bit_cnt <= bit_cnt + 1'b1;
							tx      <= shreg[1];
						end
					end
				end
				TX_STOP:
				begin
					if (bit_end)
						state <= TX_IDLE; // tx already high
				end
				default: state <= TX_IDLE;
			endcase
		end
	end

	// Shift register, payload only
	always_ff @(posedge clk)
	begin
		if (rd)
			shreg <= r_data;
		else if (state == TX_DATA && bit_end)
			shreg <= shreg >> 1;
	end

	// Line must rest high between frames
	a_idle_high: assert property (@(posedge clk) disable iff (!arst_n)
		(state == TX_IDLE) |-> tx);

endmodule

/* run_sim.sh */
#!/bin/sh
# Build and run the UART loopback testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert -f sources.f \
	--top-module tb_uart_loopback --Mdir "$BUILD_DIR" -o sim_tb
if [ $? -ne 0 ]; then
	echo "Verilator compile failed"
	exit 1
fi

"./$BUILD_DIR/sim_tb" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -F -q "*** TEST FAILED ***" "$LOG"; then
	exit 1
fi
exit 0

/* sources.f */
design/uart_pkg.sv
design/baud_tick_gen.sv
design/byte_fifo.sv
design/uart_tx.sv
design/uart_rx.sv
design/loopback_tester.sv
design/uart_loopback_top.sv
verif/tb_uart_loopback.sv

/* verif/tb_uart_loopback.sv */
`timescale 1ns/1ps

module tb_uart_loopback
	import uart_pkg::*;
();

	localparam int BIT_CLKS    = OVERSAMPLE * CLKS_PER_TICK; // 64 cycles per serial bit
	localparam int CLEAN_TESTS = 40;
	localparam int FAULT_TESTS = 24; // Fault picked at random per test
	localparam int NUM_TESTS   = CLEAN_TESTS + FAULT_TESTS;
	localparam int RESET_CLKS  = 8;
	localparam int WATCHDOG_NS = NUM_TESTS * 14 * BIT_CLKS * 8 + 20000; // 14 bit periods each

	logic              clk;
	logic              arst_n;
	logic              test_req;
	logic [DATA_W-1:0] test_byte;
	logic              test_ack;
	logic              test_pass;
	logic              tx;
	logic              rx;
	logic              flip; // Line fault, inverts rx

	integer            seed;
	logic [31:0]       rnd;
	logic [DATA_W-1:0] prev_byte;
	int                mismatches;
	int                proto_errors;
	int                fault_tests;

	// Handshake monitor state
	logic              req_q;
	logic              ack_q;
	logic              pass_q;
	logic              req_fell_q;
	int                mon_mismatches;
	int                mon_errors;

	assign rx = tx ^ flip; // External loopback wire

	uart_loopback_top uut (
		.clk(clk), .arst_n(arst_n),
		.test_req(test_req), .test_byte(test_byte), .rx(rx),
		.test_ack(test_ack), .test_pass(test_pass), .tx(tx)
	);

	always #4 clk = ~clk; // 8 ns period

	//////////////////////////////////////////////////
	// Stimulus helpers
	//////////////////////////////////////////////////
	task automatic check_idle;
		assert (tx === 1'b1)
		else
		begin
			mismatches++;
			$display("MISMATCH tx: got %h, expected %h", tx, 1'b1);
		end
		assert (test_ack === 1'b0)
		else
		begin
			mismatches++;
			$display("MISMATCH test_ack: got %h, expected %h", test_ack, 1'b0);
		end
	endtask

	// Flip the line for 8 cycles around the centre of data bit bit_idx
	task automatic inject_fault(input int bit_idx);
		int lead;
		lead = BIT_CLKS + BIT_CLKS / 2 + bit_idx * BIT_CLKS - 4;
		@(negedge tx); // Start edge of this frame
		repeat (lead) @(posedge clk);
		#1 flip = 1'b1;
		repeat (8) @(posedge clk);
		#1 flip = 1'b0;
	endtask

	task automatic await_ack;
		@(negedge clk);
		while (!test_ack)
			@(negedge clk);
	endtask

	task automatic run_test(input logic allow_fault);
		logic [DATA_W-1:0] sent;
		logic [DATA_W-1:0] exp_byte;
		logic              exp_pass;
		logic              fault;
		int                bit_idx;
		int                hold;
		rnd  = $random(seed);
		sent = rnd[DATA_W-1:0];
		while (sent == prev_byte) // New byte every test
		begin
			rnd  = $random(seed);
			sent = rnd[DATA_W-1:0];
		end
		prev_byte = sent;
		rnd       = $random(seed);
		fault     = allow_fault && rnd[8];
		bit_idx   = int'(rnd[2:0]);
		hold      = rnd[31:16] % 21; // 0 to 20 cycles
		if (fault)
			fault_tests++;

		// Reference model of the returned byte
		exp_byte = fault ? (sent ^ (8'h01 << bit_idx)) : sent;
		exp_pass = (exp_byte == sent);

		@(posedge clk);
		#1;
		test_byte = sent;
		test_req  = 1'b1;
		fork
			if (fault)
				inject_fault(bit_idx);
			await_ack();
		join

		assert (test_pass == exp_pass)
		else
		begin
			mismatches++;
			$display("MISMATCH test_pass: got %h, expected %h (byte %h, flipped bit %0d)",
				test_pass, exp_pass, sent, fault ? bit_idx : -1);
		end

		repeat (hold) @(posedge clk); // Requester holds ack open
		@(posedge clk);
		#1 test_req = 1'b0;
		while (test_ack)
			@(negedge clk);
	endtask

	//////////////////////////////////////////////////
	// Four-phase monitor, sampled mid cycle
	//////////////////////////////////////////////////
	always @(negedge clk)
	begin
		if (!arst_n)
		begin
			req_q          = 1'b0;
			ack_q          = 1'b0;
			pass_q         = 1'b0;
			req_fell_q     = 1'b0;
			mon_mismatches = 0;
			mon_errors     = 0;
		end
		else
		begin
			if (test_ack && !ack_q)
				assert (req_q)
				else
				begin
					mon_errors++;
					$display("test_ack rose while test_req was low");
				end
			if (test_ack && ack_q)
				assert (test_pass == pass_q)
				else
				begin
					mon_mismatches++;
					$display("MISMATCH test_pass: got %h, expected %h (changed during ack)",
						test_pass, pass_q);
				end
			if (req_q && !test_req)
				assert (test_ack)
				else
				begin
					mon_errors++;
					$display("test_ack fell before test_req was withdrawn");
				end
			if (req_fell_q)
				assert (!test_ack)
				else
				begin
					mon_errors++;
					$display("test_ack did not fall one cycle after test_req fell");
				end
			req_fell_q = req_q && !test_req;
			req_q      = test_req;
			ack_q      = test_ack;
			pass_q     = test_pass;
		end
	end

	//////////////////////////////////////////////////
	// Main sequence
	//////////////////////////////////////////////////
	initial
	begin
		clk          = 1'b0;
		arst_n       = 1'b0;
		test_req     = 1'b0;
		test_byte    = '0;
		flip         = 1'b0;
		seed         = 32'he64e;
		prev_byte    = '0;
		mismatches   = 0;
		proto_errors = 0;
		fault_tests  = 0;

		repeat (RESET_CLKS)
		begin
			@(negedge clk);
			check_idle();
		end
		@(posedge clk);
		#1 arst_n = 1'b1;
		repeat (2)
		begin
			@(negedge clk);
			check_idle(); // Still idle just after release
		end

		for (int i = 0; i < CLEAN_TESTS; i++)
			run_test(1'b0);
		for (int i = 0; i < FAULT_TESTS; i++)
			run_test(1'b1);

		assert (fault_tests > 0)
		else
		begin
			proto_errors++;
			$display("No test injected a line fault");
		end

		repeat (4) @(posedge clk); // Monitor settles on the negedges in between
		$display("Errors: %0d value mismatches, %0d protocol errors",
			mismatches + mon_mismatches, proto_errors + mon_errors);
		if (mismatches + mon_mismatches + proto_errors + mon_errors == 0)
			$display("*** TEST PASSED ***");
		else
			$display("*** TEST FAILED ***");
		$finish;
	end

	// Watchdog
	initial
	begin
		#(WATCHDOG_NS);
		$display("Timeout: the tests did not finish within %0d ns", WATCHDOG_NS);
		$display("*** TEST FAILED ***");
		$finish;
	end

endmodule
